//--- design/gpio_atr.sv
/*
 * Front-end ATR GPIO
 *   Four programmable output words, state from the run flags,
 *   registered GPIO output and transmit indication
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module gpio_atr (
   input  logic                          radio_clk,
   input  logic                          radio_rst,
   input  logic                          i_set_stb,
   input  logic [`RADIO_SET_ADDR_W-1:0]  i_set_addr,
   input  logic [`RADIO_SET_DATA_W-1:0]  i_set_data,
   input  logic                          i_rx_run,
   input  logic                          i_tx_run,
   output logic [`RADIO_FE_GPIO_W-1:0]   o_fe_gpio,
   output radio_pkg::atr_state_e         o_atr_state,
   output logic                          o_tx_active
);

   logic [`RADIO_FE_GPIO_W-1:0]   atr_word [4];
   logic [`RADIO_SET_ADDR_W-1:0]  atr_off;
   logic                          wr_atr;

   // Word offset within the four ATR addresses
   assign atr_off = i_set_addr - `RADIO_SR_ATR;
   assign wr_atr  = i_set_stb && (atr_off < 8'd4);

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         for (int i = 0; i < 4; i++) begin
            atr_word[i] <= `RADIO_RST_ATR_WORD;
         end
         o_atr_state <= radio_pkg::ATR_IDLE;
         o_fe_gpio   <= '0;
         o_tx_active <= 1'b0;
      end else begin
         if (wr_atr) begin
            atr_word[atr_off[1:0]] <= i_set_data[`RADIO_FE_GPIO_W-1:0];
         end
         o_atr_state <= radio_pkg::atr_state_e'({i_tx_run, i_rx_run});
         // Output stage follows the state by one cycle
         o_fe_gpio   <= atr_word[o_atr_state];
         o_tx_active <= (o_atr_state == radio_pkg::ATR_TX_ONLY) ||
                        (o_atr_state == radio_pkg::ATR_FULL_DUPLEX);
      end
   end

   // Transmit indication follows the tx run flag through the state stage
   a_tx_only_when_sending : assert property (
      @(posedge radio_clk) disable iff (radio_rst)
      o_tx_active |-> $past(i_tx_run, 2)
   );

endmodule

//--- design/radio_consts.svh
/*
 * Shared constants of the radio core
 *   Settings bus, readback, time, sample and GPIO widths
 *   Settings register addresses
 *   Reset defaults of the settings and time registers
 */
`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Bus and data widths
//////////////////////////////////////////////////////////////////////
`define RADIO_SET_ADDR_W      8
`define RADIO_SET_DATA_W      32
`define RADIO_RB_W            64
`define RADIO_TIME_W          64
// I in the high half, Q in the low half
`define RADIO_SAMPLE_W        32
`define RADIO_FE_GPIO_W       32

//////////////////////////////////////////////////////////////////////
// Settings addresses
//////////////////////////////////////////////////////////////////////
`define RADIO_SR_LOOPBACK     8'd6
// Four words follow: idle, rx only, tx only, full duplex
`define RADIO_SR_ATR          8'd12
`define RADIO_SR_TEST         8'd21
`define RADIO_SR_CODEC_IDLE   8'd22
`define RADIO_SR_READBACK     8'd32
`define RADIO_SR_TIME_HI      8'd128
`define RADIO_SR_TIME_LO      8'd129
// Bit 0 set defers the next time load to a PPS edge
`define RADIO_SR_TIME_CTRL    8'd130

//////////////////////////////////////////////////////////////////////
// Reset defaults
//////////////////////////////////////////////////////////////////////
`define RADIO_RST_TEST_WORD   32'h0000_0000
`define RADIO_RST_IDLE_WORD   32'h0000_0000
`define RADIO_RST_ATR_WORD    32'h0000_0000
`define RADIO_RST_TIME        64'h0000_0000_0000_0000

`endif

//--- design/radio_core.sv
/*
 * Radio clock control core, top level
 *   Settings registers, timekeeper, front-end ATR GPIO,
 *   codec sample registers and the readback multiplexer
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_core (
   input  logic                          radio_clk,
   input  logic                          radio_rst,
   input  logic                          i_set_stb,
   input  logic [`RADIO_SET_ADDR_W-1:0]  i_set_addr,
   input  logic [`RADIO_SET_DATA_W-1:0]  i_set_data,
   input  logic [`RADIO_SAMPLE_W-1:0]    i_rx,
   input  logic [`RADIO_SAMPLE_W-1:0]    i_tx_sample,
   input  logic                          i_tx_run,
   input  logic                          i_rx_run,
   input  logic                          i_pps,
   input  logic                          i_time_sync,
   output logic [`RADIO_SAMPLE_W-1:0]    o_tx,
   output logic [`RADIO_SAMPLE_W-1:0]    o_rx_fe,
   output logic [`RADIO_FE_GPIO_W-1:0]   o_fe_gpio,
   output logic [`RADIO_TIME_W-1:0]      o_vita_time,
   output logic [`RADIO_RB_W-1:0]        o_rb_data,
   output logic                          o_tx_is_running
);

   logic                          loopback;
   logic [`RADIO_SET_DATA_W-1:0]  test_word;
   logic [`RADIO_SAMPLE_W-1:0]    tx_idle;
   radio_pkg::rb_sel_e            rb_sel;
   logic [`RADIO_TIME_W-1:0]      vita_time_pps;
   radio_pkg::atr_state_e         atr_state;

   //////////////////////////////////////////////////////////////////////
   // Settings bus consumers
   //////////////////////////////////////////////////////////////////////
   radio_settings u_settings (
      .radio_clk   (radio_clk),
      .radio_rst   (radio_rst),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .o_loopback  (loopback),
      .o_test_word (test_word),
      .o_tx_idle   (tx_idle),
      .o_rb_sel    (rb_sel)
   );

   timekeeper u_timekeeper (
      .radio_clk       (radio_clk),
      .radio_rst       (radio_rst),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (i_set_addr),
      .i_set_data      (i_set_data),
      .i_pps           (i_pps),
      .i_time_sync     (i_time_sync),
      .o_vita_time     (o_vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

   gpio_atr u_fe_atr (
      .radio_clk   (radio_clk),
      .radio_rst   (radio_rst),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rx_run    (i_rx_run),
      .i_tx_run    (i_tx_run),
      .o_fe_gpio   (o_fe_gpio),
      .o_atr_state (atr_state),
      .o_tx_active (o_tx_is_running)
   );

   //////////////////////////////////////////////////////////////////////
   // Codec side and readback
   //////////////////////////////////////////////////////////////////////
   radio_frontend u_frontend (
      .radio_clk   (radio_clk),
      .radio_rst   (radio_rst),
      .i_tx_run    (i_tx_run),
      .i_tx_sample (i_tx_sample),
      .i_tx_idle   (tx_idle),
      .i_loopback  (loopback),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rx_fe     (o_rx_fe)
   );

   readback_mux u_rb_mux (
      .radio_clk       (radio_clk),
      .radio_rst       (radio_rst),
      .i_rb_sel        (rb_sel),
      .i_test_word     (test_word),
      .i_vita_time     (o_vita_time),
      .i_vita_time_pps (vita_time_pps),
      .i_tx            (o_tx),
      .i_rx            (o_rx_fe),
      .i_fe_gpio       (o_fe_gpio),
      .i_tx_run        (i_tx_run),
      .i_rx_run        (i_rx_run),
      .i_atr_state     (atr_state),
      .o_rb_data       (o_rb_data)
   );

endmodule

//--- design/radio_frontend.sv
/*
 * Codec side sample registers
 *   TX output with idle word substitution,
 *   RX input with digital loopback from TX
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_frontend (
   input  logic                        radio_clk,
   input  logic                        radio_rst,
   input  logic                        i_tx_run,
   input  logic [`RADIO_SAMPLE_W-1:0]  i_tx_sample,
   input  logic [`RADIO_SAMPLE_W-1:0]  i_tx_idle,
   input  logic                        i_loopback,
   input  logic [`RADIO_SAMPLE_W-1:0]  i_rx,
   output logic [`RADIO_SAMPLE_W-1:0]  o_tx,
   output logic [`RADIO_SAMPLE_W-1:0]  o_rx_fe
);

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         o_tx    <= '0;
         o_rx_fe <= '0;
      end else begin
         // Codec sees the idle word whenever transmit is stopped
         o_tx    <= i_tx_run ? i_tx_sample : i_tx_idle;
         // Loopback takes the registered TX word
         o_rx_fe <= i_loopback ? o_tx : i_rx;
      end
   end

   a_idle_when_stopped : assert property (
      @(posedge radio_clk) disable iff (radio_rst)
      !i_tx_run |=> (o_tx == $past(i_tx_idle))
   );

endmodule

//--- design/radio_pkg.sv
/*
 * Types of the radio core
 *   atr_state_e  transmit/receive state of the front end
 *   rb_sel_e     readback word select codes
 */
package radio_pkg;

   // Encoded as {tx_run, rx_run}, which also indexes the ATR words
   typedef enum logic [1:0] {
      ATR_IDLE        = 2'd0,
      ATR_RX_ONLY     = 2'd1,
      ATR_TX_ONLY     = 2'd2,
      ATR_FULL_DUPLEX = 2'd3
   } atr_state_e;

   // Codes 6 and 7 are unused and read back as zero
   typedef enum logic [2:0] {
      RB_TEST       = 3'd0,
      RB_TIME       = 3'd1,
      RB_TIME_PPS   = 3'd2,
      RB_FE_SAMPLES = 3'd3,
      RB_FE_GPIO    = 3'd4,
      RB_STATUS     = 3'd5
   } rb_sel_e;

endpackage

//--- design/radio_settings.sv
/*
 * Radio settings registers
 *   Loopback enable, test word, codec idle word and readback select,
 *   each written through the settings bus
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_settings (
   input  logic                          radio_clk,
   input  logic                          radio_rst,
   input  logic                          i_set_stb,
   input  logic [`RADIO_SET_ADDR_W-1:0]  i_set_addr,
   input  logic [`RADIO_SET_DATA_W-1:0]  i_set_data,
   output logic                          o_loopback,
   output logic [`RADIO_SET_DATA_W-1:0]  o_test_word,
   output logic [`RADIO_SAMPLE_W-1:0]    o_tx_idle,
   output radio_pkg::rb_sel_e            o_rb_sel
);

   // Address decode of the current strobe
   logic wr_loopback;
   logic wr_test;
   logic wr_idle;
   logic wr_rb_sel;

   assign wr_loopback = i_set_stb && (i_set_addr == `RADIO_SR_LOOPBACK);
   assign wr_test     = i_set_stb && (i_set_addr == `RADIO_SR_TEST);
   assign wr_idle     = i_set_stb && (i_set_addr == `RADIO_SR_CODEC_IDLE);
   assign wr_rb_sel   = i_set_stb && (i_set_addr == `RADIO_SR_READBACK);

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         o_loopback  <= 1'b0;
         o_test_word <= `RADIO_RST_TEST_WORD;
         o_tx_idle   <= `RADIO_RST_IDLE_WORD;
         o_rb_sel    <= radio_pkg::RB_TEST;
      end else begin
         if (wr_loopback) begin
            o_loopback <= i_set_data[0];
         end
         if (wr_test) begin
            o_test_word <= i_set_data;
         end
         if (wr_idle) begin
            o_tx_idle <= i_set_data[`RADIO_SAMPLE_W-1:0];
         end
         // Codes outside the enum are kept and read back as zero later
         if (wr_rb_sel) begin
            o_rb_sel <= radio_pkg::rb_sel_e'(i_set_data[2:0]);
         end
      end
   end

   // Registers only move on a bus write
   a_hold_without_strobe : assert property (
      @(posedge radio_clk) disable iff (radio_rst)
      !i_set_stb |=> ($stable(o_loopback) && $stable(o_test_word) &&
                      $stable(o_tx_idle) && $stable(o_rb_sel))
   );

endmodule

//--- design/readback_mux.sv
/*
 * Readback multiplexer
 *   Registered 64-bit selection of test, time, sample,
 *   GPIO and status words
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module readback_mux (
   input  logic                          radio_clk,
   input  logic                          radio_rst,
   input  radio_pkg::rb_sel_e            i_rb_sel,
   input  logic [`RADIO_SET_DATA_W-1:0]  i_test_word,
   input  logic [`RADIO_TIME_W-1:0]      i_vita_time,
   input  logic [`RADIO_TIME_W-1:0]      i_vita_time_pps,
   input  logic [`RADIO_SAMPLE_W-1:0]    i_tx,
   input  logic [`RADIO_SAMPLE_W-1:0]    i_rx,
   input  logic [`RADIO_FE_GPIO_W-1:0]   i_fe_gpio,
   input  logic                          i_tx_run,
   input  logic                          i_rx_run,
   input  radio_pkg::atr_state_e         i_atr_state,
   output logic [`RADIO_RB_W-1:0]        o_rb_data
);

   logic [`RADIO_RB_W-1:0] rb_next;

   always_comb begin
      case (i_rb_sel)
         radio_pkg::RB_TEST       : rb_next = {{(`RADIO_RB_W-`RADIO_SET_DATA_W){1'b0}}, i_test_word};
         radio_pkg::RB_TIME       : rb_next = i_vita_time;
         radio_pkg::RB_TIME_PPS   : rb_next = i_vita_time_pps;
         radio_pkg::RB_FE_SAMPLES : rb_next = {i_tx, i_rx};
         radio_pkg::RB_FE_GPIO    : rb_next = {{(`RADIO_RB_W-`RADIO_FE_GPIO_W){1'b0}}, i_fe_gpio};
         // State in 3:2, rx run in 1, tx run in 0
         radio_pkg::RB_STATUS     : rb_next = {{(`RADIO_RB_W-4){1'b0}}, i_atr_state,
                                               i_rx_run, i_tx_run};
         default                  : rb_next = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         o_rb_data <= '0;
      end else begin
         o_rb_data <= rb_next;
      end
   end

endmodule

//--- design/timekeeper.sv
/*
 * 64-bit timekeeper
 *   Free running cycle counter, PPS edge detect and PPS time latch,
 *   immediate or PPS aligned load through the settings bus
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module timekeeper (
   input  logic                          radio_clk,
   input  logic                          radio_rst,
   input  logic                          i_set_stb,
   input  logic [`RADIO_SET_ADDR_W-1:0]  i_set_addr,
   input  logic [`RADIO_SET_DATA_W-1:0]  i_set_data,
   input  logic                          i_pps,
   input  logic                          i_time_sync,
   output logic [`RADIO_TIME_W-1:0]      o_vita_time,
   output logic [`RADIO_TIME_W-1:0]      o_vita_time_pps
);

   logic [`RADIO_SET_DATA_W-1:0]  time_hi;
   logic                          load_at_pps;
   logic                          load_pending;
   logic [`RADIO_TIME_W-1:0]      pending_time;
   logic                          pps_in;
   logic                          pps_d;
   logic                          pps_edge;
   logic                          wr_lo;
   logic                          load_now;
   logic                          load_pps;

   // Sync input behaves as a second PPS source
   assign pps_in   = i_pps | i_time_sync;
   assign pps_edge = pps_in & ~pps_d;

   assign wr_lo    = i_set_stb && (i_set_addr == `RADIO_SR_TIME_LO);
   assign load_now = wr_lo && !load_at_pps;
   assign load_pps = pps_edge && load_pending;

   //////////////////////////////////////////////////////////////////////
   // Settings side
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         time_hi      <= '0;
         load_at_pps  <= 1'b0;
         load_pending <= 1'b0;
         pps_d        <= 1'b0;
      end else begin
         pps_d <= pps_in;
         if (i_set_stb && (i_set_addr == `RADIO_SR_TIME_HI)) begin
            time_hi <= i_set_data;
         end
         if (i_set_stb && (i_set_addr == `RADIO_SR_TIME_CTRL)) begin
            load_at_pps <= i_set_data[0];
         end
         // A new deferred write wins over a PPS edge in the same cycle
         if (wr_lo && load_at_pps) begin
            load_pending <= 1'b1;
         end else if (pps_edge) begin
            load_pending <= 1'b0;
         end
      end
   end

   // Deferred load value
   always_ff @(posedge radio_clk) begin
      if (wr_lo && load_at_pps) begin
         pending_time <= {time_hi, i_set_data};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Counter and PPS latch
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (radio_rst) begin
         o_vita_time     <= `RADIO_RST_TIME;
         o_vita_time_pps <= `RADIO_RST_TIME;
      end else begin
         if (load_now) begin
            o_vita_time <= {time_hi, i_set_data};
         end else if (load_pps) begin
            o_vita_time <= pending_time;
         end else begin
            o_vita_time <= o_vita_time + 1'b1;
         end
         // Latch sees the count from before any load on this edge
         if (pps_edge) begin
            o_vita_time_pps <= o_vita_time;
         end
      end
   end

   a_count_by_one : assert property (
      @(posedge radio_clk) disable iff (radio_rst)
      !(load_now || load_pps) |=> (o_vita_time == $past(o_vita_time) + 1'b1)
   );

endmodule

//--- filelist.f
+incdir+design
design/radio_pkg.sv
design/radio_settings.sv
design/timekeeper.sv
design/gpio_atr.sv
design/radio_frontend.sv
design/readback_mux.sv
design/radio_core.sv
verif/radio_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the radio core testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=radio_core_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$TOP" -f filelist.f -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- verif/radio_core_tb.sv
/*
 * Testbench of the radio core
 *   Clock and reset, table of stimulus and expected values,
 *   compare task, window checks for time values and a watchdog
 */
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_core_tb;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   // Cycles a drive or write entry waits for the DUT to settle
   localparam int ENTRY_WAIT   = 4;
   localparam logic [63:0] LOAD_T1 = 64'h0000_0012_3456_0000;
   localparam logic [63:0] LOAD_T2 = 64'h0000_00ab_0000_0000;

   typedef enum int {
      OP_WR, OP_RUN, OP_SAMP, OP_PPS,
      OP_CHK_RB, OP_CHK_TX, OP_CHK_RXFE, OP_CHK_GPIO, OP_CHK_TXRUN,
      OP_CHK_STEP, OP_CHK_TIME, OP_CHK_RB_WIN
   } step_kind_e;

   // lo is the written value, the expected value or the window floor
   typedef struct {
      step_kind_e  op;
      logic [7:0]  addr;
      logic [63:0] lo;
      logic [63:0] hi;
      string       name;
   } entry_t;

   logic                          radio_clk;
   logic                          radio_rst;
   logic                          i_set_stb;
   logic [`RADIO_SET_ADDR_W-1:0]  i_set_addr;
   logic [`RADIO_SET_DATA_W-1:0]  i_set_data;
   logic [`RADIO_SAMPLE_W-1:0]    i_rx;
   logic [`RADIO_SAMPLE_W-1:0]    i_tx_sample;
   logic                          i_tx_run;
   logic                          i_rx_run;
   logic                          i_pps;
   logic                          i_time_sync;
   logic [`RADIO_SAMPLE_W-1:0]    o_tx;
   logic [`RADIO_SAMPLE_W-1:0]    o_rx_fe;
   logic [`RADIO_FE_GPIO_W-1:0]   o_fe_gpio;
   logic [`RADIO_TIME_W-1:0]      o_vita_time;
   logic [`RADIO_RB_W-1:0]        o_rb_data;
   logic                          o_tx_is_running;

   entry_t      table_q[$];
   logic        table_ready = 1'b0;
   integer      seed;
   logic [31:0] test_word;
   logic [31:0] idle_word;
   logic [31:0] tx_samp;
   logic [31:0] rx_samp;
   logic [31:0] atr_words [4];

   radio_core UUT (.*);

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Reporting
   //////////////////////////////////////////////////////////////////////
   task automatic report_failure();
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (act !== exp) begin
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
         report_failure();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Table construction
   //////////////////////////////////////////////////////////////////////
   function automatic void add_entry(input step_kind_e op, input logic [7:0] addr,
                                     input logic [63:0] lo, input logic [63:0] hi,
                                     input string name);
      entry_t e;
      e.op   = op;
      e.addr = addr;
      e.lo   = lo;
      e.hi   = hi;
      e.name = name;
      table_q.push_back(e);
   endfunction

   function automatic void add_write(input logic [7:0] addr, input logic [31:0] data);
      add_entry(OP_WR, addr, {32'd0, data}, 64'd0, "write");
   endfunction

   function automatic void add_check(input step_kind_e op, input logic [63:0] exp,
                                     input string name);
      add_entry(op, 8'd0, exp, 64'd0, name);
   endfunction

   task automatic build_table();
      logic [1:0] idx;
      test_word = $random(seed);
      idle_word = $random(seed);
      tx_samp   = $random(seed);
      rx_samp   = $random(seed);
      for (int i = 0; i < 4; i++) begin
         atr_words[i] = $random(seed);
      end
      // Reset state
      add_check(OP_CHK_TX, 64'd0, "reset tx");
      add_check(OP_CHK_RXFE, 64'd0, "reset rx_fe");
      add_check(OP_CHK_GPIO, 64'd0, "reset gpio");
      add_check(OP_CHK_RB, 64'd0, "reset readback");
      add_check(OP_CHK_TXRUN, 64'd0, "reset tx running");
      // Test register and an unused select code
      add_write(`RADIO_SR_TEST, test_word);
      add_write(`RADIO_SR_READBACK, {29'd0, radio_pkg::RB_TEST});
      add_check(OP_CHK_RB, {32'd0, test_word}, "test readback");
      add_write(`RADIO_SR_READBACK, 32'd7);
      add_check(OP_CHK_RB, 64'd0, "unknown select");
      // ATR words with the run code holding rx in bit 1 and tx in bit 0
      for (int i = 0; i < 4; i++) begin
         add_write(8'(`RADIO_SR_ATR + i), atr_words[i]);
      end
      for (int run = 0; run < 4; run++) begin
         idx = {run[0], run[1]};
         add_entry(OP_RUN, 8'd0, 64'(run), 64'd0, "run flags");
         add_check(OP_CHK_GPIO, {32'd0, atr_words[idx]}, $sformatf("atr gpio %0d", run));
         add_check(OP_CHK_TXRUN, {63'd0, run[0]}, $sformatf("tx running %0d", run));
      end
      add_write(`RADIO_SR_READBACK, {29'd0, radio_pkg::RB_STATUS});
      add_entry(OP_RUN, 8'd0, 64'd2, 64'd0, "run flags");
      add_check(OP_CHK_RB, {60'd0, radio_pkg::ATR_RX_ONLY, 2'b10}, "status rx");
      add_entry(OP_RUN, 8'd0, 64'd3, 64'd0, "run flags");
      add_check(OP_CHK_RB, {60'd0, radio_pkg::ATR_FULL_DUPLEX, 2'b11}, "status full");
      // Front-end samples, idle word and loopback
      add_write(`RADIO_SR_CODEC_IDLE, idle_word);
      add_entry(OP_SAMP, 8'd0, {tx_samp, rx_samp}, 64'd0, "samples");
      add_entry(OP_RUN, 8'd0, 64'd0, 64'd0, "run flags");
      add_check(OP_CHK_TX, {32'd0, idle_word}, "tx idle");
      add_check(OP_CHK_RXFE, {32'd0, rx_samp}, "rx direct");
      add_entry(OP_RUN, 8'd0, 64'd1, 64'd0, "run flags");
      add_check(OP_CHK_TX, {32'd0, tx_samp}, "tx sample");
      add_write(`RADIO_SR_LOOPBACK, 32'd1);
      add_check(OP_CHK_RXFE, {32'd0, tx_samp}, "rx loopback");
      add_write(`RADIO_SR_READBACK, {29'd0, radio_pkg::RB_FE_SAMPLES});
      add_check(OP_CHK_RB, {tx_samp, tx_samp}, "samples loopback");
      add_write(`RADIO_SR_LOOPBACK, 32'd0);
      add_check(OP_CHK_RB, {tx_samp, rx_samp}, "samples direct");
      add_entry(OP_RUN, 8'd0, 64'd0, 64'd0, "run flags");
      add_check(OP_CHK_TX, {32'd0, idle_word}, "tx idle again");
      // Time counting, immediate load, then a load held for PPS
      add_check(OP_CHK_STEP, 64'd0, "time step");
      add_write(`RADIO_SR_TIME_HI, LOAD_T1[63:32]);
      add_write(`RADIO_SR_TIME_LO, LOAD_T1[31:0]);
      add_entry(OP_CHK_TIME, 8'd0, LOAD_T1, LOAD_T1 + ENTRY_WAIT, "immediate load");
      add_check(OP_CHK_STEP, 64'd0, "time step after load");
      add_write(`RADIO_SR_TIME_CTRL, 32'd1);
      add_write(`RADIO_SR_TIME_HI, LOAD_T2[63:32]);
      add_write(`RADIO_SR_TIME_LO, LOAD_T2[31:0]);
      add_entry(OP_CHK_TIME, 8'd0, LOAD_T1, LOAD_T1 + 64'd64, "no load before pps");
      add_entry(OP_PPS, 8'd0, 64'd0, 64'd0, "pps pulse");
      add_entry(OP_CHK_TIME, 8'd0, LOAD_T2, LOAD_T2 + ENTRY_WAIT, "pps load");
      add_write(`RADIO_SR_READBACK, {29'd0, radio_pkg::RB_TIME_PPS});
      add_entry(OP_CHK_RB_WIN, 8'd0, LOAD_T1, LOAD_T1 + 64'd64, "pps latch");
      add_write(`RADIO_SR_READBACK, {29'd0, radio_pkg::RB_TIME});
      add_entry(OP_CHK_RB_WIN, 8'd0, LOAD_T2, LOAD_T2 + 64'd32, "time readback");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Table execution
   //////////////////////////////////////////////////////////////////////
   task automatic apply_entry(input entry_t e);
      logic [63:0] t0;
      logic [63:0] act;
      case (e.op)
         OP_WR: begin
            @(posedge radio_clk);
            i_set_stb  <= 1'b1;
            i_set_addr <= e.addr;
            i_set_data <= e.lo[31:0];
            @(posedge radio_clk);
            i_set_stb  <= 1'b0;
            repeat (ENTRY_WAIT) @(posedge radio_clk);
         end
         OP_RUN: begin
            @(posedge radio_clk);
            i_rx_run <= e.lo[1];
            i_tx_run <= e.lo[0];
            repeat (ENTRY_WAIT) @(posedge radio_clk);
         end
         OP_SAMP: begin
            @(posedge radio_clk);
            i_tx_sample <= e.lo[63:32];
            i_rx        <= e.lo[31:0];
            repeat (ENTRY_WAIT) @(posedge radio_clk);
         end
         OP_PPS: begin
            @(posedge radio_clk);
            i_pps <= 1'b1;
            @(posedge radio_clk);
            i_pps <= 1'b0;
            repeat (ENTRY_WAIT) @(posedge radio_clk);
         end
         OP_CHK_STEP: begin
            @(negedge radio_clk);
            t0 = o_vita_time;
            @(negedge radio_clk);
            check_value(e.name, t0 + 64'd1, o_vita_time);
         end
         OP_CHK_TIME, OP_CHK_RB_WIN: begin
            @(negedge radio_clk);
            act = (e.op == OP_CHK_TIME) ? o_vita_time : o_rb_data;
            if (act < e.lo || act > e.hi) begin
               $display("mismatch %s: expected %h to %h, actual %h",
                        e.name, e.lo, e.hi, act);
               report_failure();
            end
         end
         default: begin
            // Outputs are sampled half a cycle after the edge that moved them
            @(negedge radio_clk);
            case (e.op)
               OP_CHK_TX:    check_value(e.name, e.lo, {32'd0, o_tx});
               OP_CHK_RXFE:  check_value(e.name, e.lo, {32'd0, o_rx_fe});
               OP_CHK_GPIO:  check_value(e.name, e.lo, {32'd0, o_fe_gpio});
               OP_CHK_TXRUN: check_value(e.name, e.lo, {63'd0, o_tx_is_running});
               default:      check_value(e.name, e.lo, o_rb_data);
            endcase
         end
      endcase
   endtask

   // Watchdog sized from the table length and the longest entry
   initial begin
      longint limit_ns;
      wait (table_ready === 1'b1);
      limit_ns = (RESET_CYCLES + table_q.size() * (ENTRY_WAIT + 3)) * CLK_PERIOD + 200;
      #(limit_ns);
      $display("watchdog: the table did not complete within %0d ns", limit_ns);
      report_failure();
   end

   initial begin
      radio_rst   = 1'b1;
      i_set_stb   = 1'b0;
      i_set_addr  = '0;
      i_set_data  = '0;
      i_rx        = '0;
      i_tx_sample = '0;
      i_tx_run    = 1'b0;
      i_rx_run    = 1'b0;
      i_pps       = 1'b0;
      i_time_sync = 1'b0;
      seed        = 32'he86c_261e;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge radio_clk);
      radio_rst <= 1'b0;
      foreach (table_q[i]) begin
         apply_entry(table_q[i]);
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule
